//--- alu/pa_alu.sv
`timescale 1ns/1ps

module pa_alu (
	input  pa_pkg::alu_fn_t fn,
	input  pa_pkg::word_t   a,
	input  pa_pkg::word_t   ac,
	input  logic            carry_in,
	output pa_pkg::word_t   f,
	output logic            carry,
	output logic            zero
);

	// bit 0 is the carry out, bits 1..16 the result word
	logic [0:16] sum;

	// operands widened by one bit for the carry
	logic [0:16] a_x;
	logic [0:16] ac_x;

	assign a_x  = {1'b0, a};
	assign ac_x = {1'b0, ac};

	always_comb begin
		sum = '0;
		case (fn)
			pa_pkg::F_ADD: begin
				sum = a_x + ac_x + {16'd0, carry_in};
			end
			pa_pkg::F_SUB: begin
				// borrow style, carry_in low takes one more away
				sum = a_x - ac_x - {16'd0, ~carry_in};
			end
			pa_pkg::F_AND: begin
				sum = {1'b0, a & ac};
			end
			pa_pkg::F_OR: begin
				sum = {1'b0, a | ac};
			end
			pa_pkg::F_XOR: begin
				sum = {1'b0, a ^ ac};
			end
			pa_pkg::F_PASS_A: begin
				sum = {1'b0, a};
			end
			pa_pkg::F_PASS_AC: begin
				sum = {1'b0, ac};
			end
			default: begin
				sum = '0;
			end
		endcase
	end

	assign f = sum[1:16];

	// logic functions leave bit 0 clear, so no carry there
	assign carry = sum[0];

	// zero flag on the result word only
	assign zero = (f == '0);

endmodule

//--- common/pa_pkg.sv
package pa_pkg;

	// data word, bit 0 is the most significant
	typedef logic [0:15] word_t;

	// A-bus source
	typedef logic [1:0] a_sel_t;

	localparam a_sel_t A_L  = 2'd0;
	localparam a_sel_t A_IR = 2'd1;
	localparam a_sel_t A_AR = 2'd2;
	localparam a_sel_t A_IC = 2'd3;

	// W-bus source
	typedef logic [2:0] w_sel_t;

	localparam w_sel_t W_KI  = 3'd0;
	localparam w_sel_t W_RDT = 3'd1;
	localparam w_sel_t W_IR  = 3'd2;
	localparam w_sel_t W_AT  = 3'd3;
	localparam w_sel_t W_AC  = 3'd4;
	// ALU result fed back onto W
	localparam w_sel_t W_F   = 3'd5;

	// ALU function
	typedef logic [2:0] alu_fn_t;

	localparam alu_fn_t F_ADD     = 3'd0;
	localparam alu_fn_t F_SUB     = 3'd1;
	localparam alu_fn_t F_AND     = 3'd2;
	localparam alu_fn_t F_OR      = 3'd3;
	localparam alu_fn_t F_XOR     = 3'd4;
	localparam alu_fn_t F_PASS_A  = 3'd5;
	localparam alu_fn_t F_PASS_AC = 3'd6;

	// address drive source
	typedef logic [1:0] ad_sel_t;

	localparam ad_sel_t AD_NONE = 2'd0;
	localparam ad_sel_t AD_AR   = 2'd1;
	localparam ad_sel_t AD_IC   = 2'd2;

	// register contents after reset
	localparam word_t RST_VAL = 16'h0000;

	// one micro-operation
	typedef struct packed {
		a_sel_t  a_sel;
		w_sel_t  w_sel;
		alu_fn_t alu_fn;
		ad_sel_t ad_sel;
		logic    carry_in;
		logic    ld_ac;
		logic    ld_ar;
		logic    ld_ic;
		logic    ld_at;
		logic    ar_inc;
		logic    ic_inc;
		word_t   ir;
		word_t   l;
		word_t   ki;
		word_t   rdt;
		word_t   kl;
	} pa_op_t;

	// one result
	typedef struct packed {
		word_t f;
		logic  carry;
		logic  zero;
		word_t dad;
		logic  zga;
	} pa_res_t;

endpackage

//--- list.f
common/pa_pkg.sv
alu/pa_alu.sv
verilog/pa_bus.sv
verilog/pa_regs.sv
verilog/pa.sv
sim/pa_clk.sv
sim/pa_mon.sv
sim/pa_chk.sv
sim/pa_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
out=""
verilator --binary --timing --assert --top-module pa_tb -o pa_sim -f list.f \
	&& out=$(./obj_dir/pa_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Testbench passed" \
	&& echo "run ok" \
	|| { echo "run did not pass"; exit 1; }

//--- sim/pa_chk.sv
`timescale 1ns/1ps

module pa_chk (
	input logic            clk,
	input logic            rst_n,
	input logic            op_valid,
	input logic            op_ready,
	input logic            res_valid,
	input logic            res_ready,
	input pa_pkg::pa_res_t res
);

	int rst_fails;
	int hold_fails;
	int lat_fails;

	// nothing offered while in reset
	a_rst_idle: assert property (@(posedge clk) !rst_n |-> !res_valid)
	else begin
		$error("res_valid high while reset is active");
		rst_fails++;
	end

	// stalled result keeps its payload
	a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid && $stable(res))
	else begin
		$error("result changed or dropped while stalled");
		hold_fails++;
	end

	// one cycle from accept to result
	a_res_lat: assert property (@(posedge clk) disable iff (!rst_n)
		op_valid && op_ready |=> res_valid)
	else begin
		$error("res_valid not high one cycle after accept");
		lat_fails++;
	end

endmodule

bind pa pa_chk chk (.*);

//--- sim/pa_clk.sv
`timescale 1ns/1ps

module pa_clk (
	output logic clk
);

	// 20 ns period
	initial begin
		clk = 1'b0;
	end

	always #10 clk = ~clk;

endmodule

//--- sim/pa_mon.sv
`timescale 1ns/1ps

module pa_mon (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            op_valid,
	input  logic            op_ready,
	input  pa_pkg::pa_op_t  op,
	input  logic            res_valid,
	input  logic            res_ready,
	input  pa_pkg::pa_res_t res,
	output int              errors,
	output int              compared,
	output int              pending
);

	// model copies of the working registers
	pa_pkg::word_t m_ac;
	pa_pkg::word_t m_ar;
	pa_pkg::word_t m_ic;
	pa_pkg::word_t m_at;

	// results still owed by the DUT in arrival order
	pa_pkg::pa_res_t exp_q[$];

	// returns {carry, f}
	function automatic logic [16:0] alu_model(input pa_pkg::alu_fn_t fn,
		input pa_pkg::word_t a, input pa_pkg::word_t b, input logic ci);
		logic [31:0] t;
		case (fn)
			pa_pkg::F_ADD:     t = 32'(a) + 32'(b) + 32'(ci);
			// a clear carry_in borrows one more
			pa_pkg::F_SUB:     t = 32'(a) - 32'(b) - 32'(!ci);
			pa_pkg::F_AND:     t = 32'(a & b);
			pa_pkg::F_OR:      t = 32'(a | b);
			pa_pkg::F_XOR:     t = 32'(a ^ b);
			pa_pkg::F_PASS_A:  t = 32'(a);
			pa_pkg::F_PASS_AC: t = 32'(b);
			default:           t = 32'd0;
		endcase
		return t[16:0];
	endfunction

	always @(posedge clk or negedge rst_n) begin : model_step
		pa_pkg::word_t   a_v;
		pa_pkg::word_t   w_v;
		logic [16:0]     cf;
		logic            exp_valid;
		pa_pkg::pa_res_t e;
		if (!rst_n) begin
			m_ac = pa_pkg::RST_VAL;
			m_ar = pa_pkg::RST_VAL;
			m_ic = pa_pkg::RST_VAL;
			m_at = pa_pkg::RST_VAL;
			exp_q.delete();
			errors = 0;
			compared = 0;
		end else begin
			// a result is offered exactly while one is owed
			exp_valid = (exp_q.size() != 0);
			if (res_valid !== exp_valid || op_ready !== (!exp_valid || res_ready)) begin
				$display("ERROR %0t: res_valid=%b op_ready=%b, expected %b and %b", $time,
					res_valid, op_ready, exp_valid, !exp_valid || res_ready);
				errors++;
			end
			// result leaving this edge belongs to an earlier op
			if (res_valid && res_ready) begin
				if (exp_q.size() == 0) begin
					$display("result transfer at %0t with no operation outstanding", $time);
					errors++;
				end else begin
					e = exp_q.pop_front();
					compared++;
					if (res !== e) begin
						$display("ERROR %0t: got f=%h c=%b z=%b dad=%h zga=%b", $time,
							res.f, res.carry, res.zero, res.dad, res.zga);
						$display("ERROR %0t: exp f=%h c=%b z=%b dad=%h zga=%b", $time,
							e.f, e.carry, e.zero, e.dad, e.zga);
						errors++;
					end
				end
			end
			if (op_valid && op_ready) begin
				case (op.a_sel)
					pa_pkg::A_L:  a_v = op.l;
					pa_pkg::A_IR: a_v = op.ir;
					pa_pkg::A_AR: a_v = m_ar;
					default:      a_v = m_ic;
				endcase
				cf = alu_model(op.alu_fn, a_v, m_ac, op.carry_in);
				e.f = cf[15:0];
				e.carry = cf[16];
				e.zero = (cf[15:0] == 16'd0);
				case (op.w_sel)
					pa_pkg::W_KI:  w_v = op.ki;
					pa_pkg::W_RDT: w_v = op.rdt;
					pa_pkg::W_IR:  w_v = op.ir;
					pa_pkg::W_AT:  w_v = m_at;
					pa_pkg::W_AC:  w_v = m_ac;
					pa_pkg::W_F:   w_v = e.f;
					default:       w_v = 16'd0;
				endcase
				if (op.ad_sel == pa_pkg::AD_AR) begin
					e.dad = m_ar;
				end else if (op.ad_sel == pa_pkg::AD_IC) begin
					e.dad = m_ic;
				end else begin
					e.dad = 16'd0;
				end
				e.zga = (e.dad == op.kl);
				exp_q.push_back(e);
				// register writes use the pre-edge values
				if (op.ld_ac) m_ac = w_v;
				if (op.ld_at) m_at = e.f;
				if (op.ld_ar) m_ar = w_v;
				else if (op.ar_inc) m_ar = m_ar + 16'd1;
				if (op.ld_ic) m_ic = w_v;
				else if (op.ic_inc) m_ic = m_ic + 16'd1;
			end
		end
		pending = exp_q.size();
	end

endmodule

//--- sim/pa_tb.sv
`timescale 1ns/1ps

module pa_tb;

	localparam int N_OPS = 2000;
	localparam int WAIT_LIMIT = 200;
	localparam int DRAIN_LIMIT = 1000;

	logic            clk;
	logic            rst_n;
	logic            op_valid;
	logic            op_ready;
	pa_pkg::pa_op_t  op;
	logic            res_valid;
	logic            res_ready;
	pa_pkg::pa_res_t res;
	int              errors;
	int              compared;
	int              pending;
	int              n_sent;
	logic            timed_out;

	pa_clk u_clk (.clk(clk));

	pa dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.op_valid  (op_valid),
		.op_ready  (op_ready),
		.op        (op),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res       (res)
	);

	pa_mon mon (
		.clk       (clk),
		.rst_n     (rst_n),
		.op_valid  (op_valid),
		.op_ready  (op_ready),
		.op        (op),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res       (res),
		.errors    (errors),
		.compared  (compared),
		.pending   (pending)
	);

	// corner values half of the time, to hit carries and wraparound
	function automatic pa_pkg::word_t pick_word();
		case ($urandom_range(7))
			0:       return 16'h0000;
			1:       return 16'hffff;
			2:       return 16'h8000;
			3:       return 16'h0001;
			default: return 16'($urandom);
		endcase
	endfunction

	function automatic pa_pkg::pa_op_t random_op();
		pa_pkg::pa_op_t o;
		o.a_sel    = 2'($urandom_range(3));
		o.w_sel    = 3'($urandom_range(7));
		o.alu_fn   = 3'($urandom_range(7));
		o.ad_sel   = 2'($urandom_range(3));
		o.carry_in = 1'($urandom_range(1));
		o.ld_ac    = ($urandom_range(2) == 0);
		o.ld_ar    = ($urandom_range(2) == 0);
		o.ld_ic    = ($urandom_range(2) == 0);
		o.ld_at    = ($urandom_range(2) == 0);
		o.ar_inc   = ($urandom_range(1) == 0);
		o.ic_inc   = ($urandom_range(1) == 0);
		o.ir       = pick_word();
		o.l        = pick_word();
		o.ki       = pick_word();
		o.rdt      = pick_word();
		o.kl       = pick_word();
		// force an address match now and then, key taken from the model
		if ($urandom_range(2) == 0) begin
			case (o.ad_sel)
				pa_pkg::AD_AR: o.kl = mon.m_ar;
				pa_pkg::AD_IC: o.kl = mon.m_ic;
				default:       o.kl = 16'd0;
			endcase
		end
		return o;
	endfunction

	task automatic next_cycle();
		@(negedge clk);
		res_ready = ($urandom_range(3) != 0);
	endtask

	task automatic send_op(input pa_pkg::pa_op_t o);
		int n;
		int gap;
		n = 0;
		op = o;
		op_valid = 1'b1;
		@(posedge clk);
		while (!op_ready && !timed_out) begin
			if (n == WAIT_LIMIT) begin
				$display("timeout: op_ready stayed low for %0d cycles", WAIT_LIMIT);
				timed_out = 1'b1;
			end else begin
				next_cycle();
				@(posedge clk);
				n++;
			end
		end
		if (!timed_out) n_sent++;
		next_cycle();
		op_valid = 1'b0;
		gap = $urandom_range(2);
		repeat (gap) next_cycle();
	endtask

	task automatic drain();
		int n;
		n = 0;
		while ((pending != 0 || res_valid) && n < DRAIN_LIMIT) begin
			@(negedge clk);
			res_ready = 1'b1;
			n++;
		end
		if (pending != 0 || res_valid) begin
			$display("timeout: %0d results still outstanding after drain", pending);
			timed_out = 1'b1;
		end
	endtask

	initial begin
		pa_pkg::pa_op_t first;
		int assert_fails;
		void'($urandom(32'hed21));
		rst_n = 1'b0;
		op_valid = 1'b0;
		res_ready = 1'b0;
		op = '0;
		n_sent = 0;
		timed_out = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// ar straight through the ALU, still at its reset value
		first = '0;
		first.alu_fn = pa_pkg::F_PASS_A;
		first.a_sel = pa_pkg::A_AR;
		first.ad_sel = pa_pkg::AD_IC;
		send_op(first);
		for (int i = 1; i < N_OPS && !timed_out; i++) begin
			send_op(random_op());
		end
		if (!timed_out) drain();
		assert_fails = dut.chk.rst_fails + dut.chk.hold_fails + dut.chk.lat_fails;
		$display("sent %0d, checked %0d, errors %0d, missing %0d, assertion failures %0d",
			n_sent, compared, errors, n_sent - compared, assert_fails);
		if (timed_out || errors != 0 || assert_fails != 0 || compared != n_sent) begin
			$display("Testbench failed");
		end else begin
			$display("Testbench passed");
		end
		$finish;
	end

endmodule

//--- verilog/pa.sv
`timescale 1ns/1ps

module pa (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            op_valid,
	output logic            op_ready,
	input  pa_pkg::pa_op_t  op,
	output logic            res_valid,
	input  logic            res_ready,
	output pa_pkg::pa_res_t res
);

	pa_pkg::word_t ac;
	pa_pkg::word_t ar;
	pa_pkg::word_t ic;
	pa_pkg::word_t at;
	pa_pkg::word_t a;
	pa_pkg::word_t w;
	pa_pkg::word_t f;
	logic          carry;
	logic          zero;

	pa_pkg::word_t   dad;
	logic            zga;
	pa_pkg::pa_res_t res_nxt;
	logic            accept;

	// take a new op when the result slot is free or draining
	assign op_ready = !res_valid || res_ready;
	assign accept   = op_valid && op_ready;

	pa_regs u_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.accept (accept),
		.ld_ac  (op.ld_ac),
		.ld_ar  (op.ld_ar),
		.ld_ic  (op.ld_ic),
		.ld_at  (op.ld_at),
		.ar_inc (op.ar_inc),
		.ic_inc (op.ic_inc),
		.w      (w),
		.f      (f),
		.ac     (ac),
		.ar     (ar),
		.ic     (ic),
		.at     (at)
	);

	pa_bus u_bus (
		.a_sel (op.a_sel),
		.w_sel (op.w_sel),
		.l     (op.l),
		.ir    (op.ir),
		.ki    (op.ki),
		.rdt   (op.rdt),
		.ar    (ar),
		.ic    (ic),
		.at    (at),
		.ac    (ac),
		.f     (f),
		.a     (a),
		.w     (w)
	);

	pa_alu u_alu (
		.fn       (op.alu_fn),
		.a        (a),
		.ac       (ac),
		.carry_in (op.carry_in),
		.f        (f),
		.carry    (carry),
		.zero     (zero)
	);

	// address from one register only, never both
	always_comb begin
		case (op.ad_sel)
			pa_pkg::AD_NONE: dad = '0;
			pa_pkg::AD_AR:   dad = ar;
			pa_pkg::AD_IC:   dad = ic;
			default:         dad = '0;
		endcase
	end

	// full-word match of the address against the key
	assign zga = (dad == op.kl);

	assign res_nxt = '{f: f, carry: carry, zero: zero, dad: dad, zga: zga};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else if (accept) begin
			res_valid <= 1'b1;
		end else if (res_ready) begin
			res_valid <= 1'b0;
		end
	end

	// result payload, held while the consumer stalls
	always_ff @(posedge clk) begin
		if (accept) begin
			res <= res_nxt;
		end
	end

endmodule

//--- verilog/pa_bus.sv
`timescale 1ns/1ps

module pa_bus (
	input  pa_pkg::a_sel_t a_sel,
	input  pa_pkg::w_sel_t w_sel,
	input  pa_pkg::word_t  l,
	input  pa_pkg::word_t  ir,
	input  pa_pkg::word_t  ki,
	input  pa_pkg::word_t  rdt,
	input  pa_pkg::word_t  ar,
	input  pa_pkg::word_t  ic,
	input  pa_pkg::word_t  at,
	input  pa_pkg::word_t  ac,
	input  pa_pkg::word_t  f,
	output pa_pkg::word_t  a,
	output pa_pkg::word_t  w
);

	// A bus, feeds the ALU left operand
	always_comb begin
		case (a_sel)
			pa_pkg::A_L:  a = l;
			pa_pkg::A_IR: a = ir;
			pa_pkg::A_AR: a = ar;
			pa_pkg::A_IC: a = ic;
			default:      a = '0;
		endcase
	end

	// W bus, feeds the register loads
	always_comb begin
		case (w_sel)
			pa_pkg::W_KI:  w = ki;
			pa_pkg::W_RDT: w = rdt;
			pa_pkg::W_IR:  w = ir;
			pa_pkg::W_AT:  w = at;
			pa_pkg::W_AC:  w = ac;
			// loop back of the ALU result
			pa_pkg::W_F:   w = f;
			default:       w = '0;
		endcase
	end

endmodule

//--- verilog/pa_regs.sv
`timescale 1ns/1ps

module pa_regs (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          accept,
	input  logic          ld_ac,
	input  logic          ld_ar,
	input  logic          ld_ic,
	input  logic          ld_at,
	input  logic          ar_inc,
	input  logic          ic_inc,
	input  pa_pkg::word_t w,
	input  pa_pkg::word_t f,
	output pa_pkg::word_t ac,
	output pa_pkg::word_t ar,
	output pa_pkg::word_t ic,
	output pa_pkg::word_t at
);

	// next values of the counting registers
	pa_pkg::word_t ar_nxt;
	pa_pkg::word_t ic_nxt;

	// load wins over increment
	always_comb begin
		ar_nxt = ar;
		if (ld_ar) begin
			ar_nxt = w;
		end else if (ar_inc) begin
			ar_nxt = ar + 16'd1;
		end
	end

	always_comb begin
		ic_nxt = ic;
		if (ld_ic) begin
			ic_nxt = w;
		end else if (ic_inc) begin
			ic_nxt = ic + 16'd1;
		end
	end

	// accumulator, loaded from W
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ac <= pa_pkg::RST_VAL;
		end else if (accept && ld_ac) begin
			ac <= w;
		end
	end

	// auxiliary register, loaded straight from the ALU
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			at <= pa_pkg::RST_VAL;
		end else if (accept && ld_at) begin
			at <= f;
		end
	end

	// argument register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ar <= pa_pkg::RST_VAL;
		end else if (accept) begin
			ar <= ar_nxt;
		end
	end

	// instruction counter
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ic <= pa_pkg::RST_VAL;
		end else if (accept) begin
			ic <= ic_nxt;
		end
	end

endmodule
